// File: bench/cpu_trace.txt
# M lines give a word address and the instruction word, W lines a register and its value
# The F line gives the final NZCV flags, all numbers in hex
M 00000000 e3a00005
M 00000004 e3a014ff
M 00000008 e0802001
M 0000000c e0423000
M 00000010 e22140f0
M 00000014 e20450ff
M 00000018 e1856000
M 0000001c e3e07000
M 00000020 e28f8000
M 00000024 e1a0900f
M 00000028 e297a001
M 0000002c 03a0b011
M 00000030 13a0b022
M 00000034 e3500005
M 00000038 e3500006
M 0000003c b3a0c033
M 00000040 a3a0c044
M 00000044 83a0c055
M 00000048 93a0d066
M 0000004c e3a01102
M 00000050 e2513001
M 00000054 63a04077
M 00000058 73a04088
M 0000005c b3a05099
M 00000060 e3b06102
M 00000064 43a070aa
M 00000068 53a070bb
M 0000006c 23a080cc
M 00000070 33a080dd
M 00000074 e2109000
M 00000078 c3a0a001
M 0000007c d3a0a002
M 00000080 e3a0b003
M 00000084 e25bb001
M 00000088 1afffffd
M 0000008c e3a0c012
M 00000090 ea000001
M 00000094 e3a000de
M 00000098 e3a000ad
M 0000009c 0a000001
M 000000a0 e3a010be
M 000000a4 e3a010ef
M 000000a8 3afffffc
M 000000ac e08a200c
M 000000b0 eafffffe
M 000000b4 e3a000f0
M 000000b8 e3a000f0
M 000000bc e3a000f0
M 000000c0 e3a000f0
M 000000c4 e3a000f0
M 000000c8 e3a000f0
M 000000cc e3a000f0
M 000000d0 e3a000f0
W 0 00000005
W 1 ff000000
W 2 ff000005
W 3 ff000000
W 4 ff0000f0
W 5 000000f0
W 6 000000f5
W 7 ffffffff
W 8 00000028
W 9 0000002c
W a 00000000
W b 00000011
W c 00000033
W d 00000066
W 1 80000000
W 3 7fffffff
W 4 00000077
W 5 00000099
W 6 80000000
W 7 000000aa
W 8 000000cc
W 9 00000000
W a 00000002
W b 00000003
W b 00000002
W b 00000001
W b 00000000
W c 00000012
W 2 00000014
F 6

// File: vlog.f
design/cpu_pkg.sv
design/fetch.sv
design/inst_queue.sv
design/reg_file.sv
design/execute.sv
design/cpu.sv
bench/cpu_tb.sv

// File: bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  import cpu_pkg::*;

  localparam int MAX_WRITES = 64;
  localparam int PROG_WORDS = 256;

  logic        clk_i;
  logic        reset_i;
  logic        imem_req_o;
  logic [31:0] imem_addr_o;
  logic        imem_ack_i;
  logic [31:0] imem_data_i;
  reg_write_t  wb_o;
  flags_t      flags_o;

  logic [31:0] prog_word [0:PROG_WORDS-1];
  logic        prog_valid [0:PROG_WORDS-1];
  bit          branch_target [0:PROG_WORDS-1];
  reg_write_t  exp_write [0:MAX_WRITES-1];
  flags_t      exp_flags;
  int          exp_count = 0;
  int          wr_idx = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  cpu cpu_inst (
      .clk_i       ( clk_i )
    , .reset_i     ( reset_i )
    , .imem_req_o  ( imem_req_o )
    , .imem_addr_o ( imem_addr_o )
    , .imem_ack_i  ( imem_ack_i )
    , .imem_data_i ( imem_data_i )
    , .wb_o        ( wb_o )
    , .flags_o     ( flags_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Reporting and compare tasks
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_write(input reg_write_t expected, input reg_write_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t: wb_o expected en=%0b r%0d=%h, got en=%0b r%0d=%h",
                          $time, expected.en, expected.addr, expected.data,
                          actual.en, actual.addr, actual.data));
    end
  endtask

  task automatic check_flags(input flags_t expected, input flags_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t: flags_o expected NZCV=%b, got NZCV=%b",
                          $time, expected, actual));
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t: %s expected %b, got %b",
                          $time, name, expected, actual));
    end
  endtask

  task automatic check_addr(input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t: imem_addr_o expected %h, got %h",
                          $time, expected, actual));
    end
  endtask

  task automatic check_reset_outputs();
    check_level("imem_req_o", 1'b0, imem_req_o);
    check_level("wb_o.en", 1'b0, wb_o.en);
    check_flags(flags_t'(4'h0), flags_o);
  endtask

  ////////////////////
  // Trace reader
  ////////////////////

  task automatic load_trace();
    int                 fd;
    int                 code;
    logic [7:0]         kind;
    logic [31:0]        first;
    logic [31:0]        second;
    logic [8*200-1:0]   rest;
    bit                 done;
    bit                 have_flags;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog_valid[i]    = 1'b0;
      branch_target[i] = 1'b0;
    end
    done       = 1'b0;
    have_flags = 1'b0;
    fd = $fopen("bench/cpu_trace.txt", "r");
    if (fd == 0) begin
      abort_run("The trace file bench/cpu_trace.txt could not be opened");
    end
    while (!done) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        done = 1'b1;
      end else if (kind == "#") begin
        code = $fgets(rest, fd);
      end else if (kind == "M") begin
        code = $fscanf(fd, "%h %h", first, second);
        if ((first >= 4 * PROG_WORDS) || (first[1:0] != 2'b00)) begin
          abort_run($sformatf("The trace gives a word at an unusable address %h", first));
        end
        prog_word[first[9:2]]  = second;
        prog_valid[first[9:2]] = 1'b1;
      end else if (kind == "W") begin
        code = $fscanf(fd, "%h %h", first, second);
        if (exp_count >= MAX_WRITES) begin
          abort_run("The trace holds more register writes than the bench can store");
        end
        exp_write[exp_count] = {1'b1, first[3:0], second};
        exp_count++;
      end else if (kind == "F") begin
        code = $fscanf(fd, "%h", first);
        exp_flags  = first[3:0];
        have_flags = 1'b1;
      end else begin
        abort_run($sformatf("The trace holds a line of unknown kind '%c'", kind));
      end
    end
    $fclose(fd);
    if (!have_flags || (exp_count == 0)) begin
      abort_run("The trace lacks its final flags or its register writes");
    end
  endtask

  ////////////////////
  // Instruction source
  ////////////////////

  // Answers one four-phase handshake at a time, with random waits on both edges of ack
  initial begin : imem_source
    int          delay;
    bit          first_seen;
    logic [31:0] addr;
    logic [31:0] last_addr;
    logic [31:0] word;
    logic [31:0] target;
    void'($urandom(32'h1791_57e9));
    first_seen = 1'b0;
    last_addr  = '0;
    forever begin
      @(posedge clk_i);
      if (!reset_i && imem_req_o && !imem_ack_i) begin
        addr = imem_addr_o;
        if (!first_seen) begin
          check_addr(32'h0, addr);
        end
        if ((addr >= 4 * PROG_WORDS) || !prog_valid[addr[9:2]]) begin
          abort_run($sformatf("The CPU requested address %h, which the trace does not give",
                              addr));
        end else if (first_seen && (addr != last_addr + 32'd4)
                     && !branch_target[addr[9:2]]) begin
          abort_run($sformatf("The CPU requested address %h after %h with no branch to it",
                              addr, last_addr));
        end else begin
          first_seen = 1'b1;
          last_addr  = addr;
          word       = prog_word[addr[9:2]];
          // A fetched B word makes its target a legal point to restart from
          if (word[27:25] == 3'b101) begin
            target = addr + 32'd8 + {{6{word[23]}}, word[23:0], 2'b00};
            if (target < 4 * PROG_WORDS) begin
              branch_target[target[9:2]] = 1'b1;
            end
          end
          delay = $urandom % 4;
          repeat (delay) @(posedge clk_i);
          imem_data_i <= word;
          imem_ack_i  <= 1'b1;
          do @(posedge clk_i); while (imem_req_o);
          delay = $urandom % 4;
          repeat (delay) @(posedge clk_i);
          imem_ack_i <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Write monitor and timeout
  ////////////////////

  always @(posedge clk_i) begin
    if (!reset_i && (wb_o.en === 1'b1)) begin
      if (wr_idx >= exp_count) begin
        abort_run($sformatf("A write to r%0d arrived after the last expected write",
                            wb_o.addr));
      end else begin
        check_write(exp_write[wr_idx], wb_o);
        wr_idx <= wr_idx + 1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit != 0) && (cycle_count >= cycle_limit)) begin
      abort_run($sformatf("Timeout after %0d cycles with %0d of %0d writes seen",
                          cycle_count, wr_idx, exp_count));
    end
  end

  initial begin
    reset_i     = 1'b1;
    imem_ack_i  = 1'b0;
    imem_data_i = '0;
    load_trace();
    cycle_limit = 1000 + 40 * exp_count;
    @(posedge clk_i);
    repeat (3) begin
      @(posedge clk_i);
      check_reset_outputs();
    end
    reset_i <= 1'b0;
    while (wr_idx < exp_count) @(posedge clk_i);
    // Extra writes during the drain are still caught by the monitor
    repeat (20) @(posedge clk_i);
    check_flags(exp_flags, flags_o);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: design/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                clk_i,
  input  logic                reset_i,
  output logic                imem_req_o,
  output logic [31:0]         imem_addr_o,
  input  logic                imem_ack_i,
  input  logic [31:0]         imem_data_i,
  output cpu_pkg::reg_write_t wb_o,
  output cpu_pkg::flags_t     flags_o
);

  import cpu_pkg::*;

  logic                   push;
  fetch_item_t            fetch_item;
  logic [QUEUE_CNT_W-1:0] free_slots;
  logic                   queue_valid;
  fetch_item_t            head_item;
  logic                   pop;
  redirect_t              redirect;
  logic [3:0]             rn_addr;
  logic [3:0]             rm_addr;
  logic [31:0]            rn_data;
  logic [31:0]            rm_data;
  logic [31:0]            pc_plus8;
  reg_write_t             reg_write;

  fetch fetch_inst (
      .clk_i        ( clk_i )
    , .reset_i      ( reset_i )
    , .imem_ack_i   ( imem_ack_i )
    , .imem_data_i  ( imem_data_i )
    , .imem_req_o   ( imem_req_o )
    , .imem_addr_o  ( imem_addr_o )
    , .free_slots_i ( free_slots )
    , .redirect_i   ( redirect )
    , .push_o       ( push )
    , .item_o       ( fetch_item )
  );

  inst_queue queue_inst (
      .clk_i        ( clk_i )
    , .reset_i      ( reset_i )
    , .push_i       ( push )
    , .item_i       ( fetch_item )
    , .pop_i        ( pop )
    , .flush_i      ( redirect.valid )
    , .valid_o      ( queue_valid )
    , .item_o       ( head_item )
    , .free_slots_o ( free_slots )
  );

  execute execute_inst (
      .clk_i      ( clk_i )
    , .reset_i    ( reset_i )
    , .valid_i    ( queue_valid )
    , .item_i     ( head_item )
    , .pop_o      ( pop )
    , .rn_addr_o  ( rn_addr )
    , .rm_addr_o  ( rm_addr )
    , .rn_data_i  ( rn_data )
    , .rm_data_i  ( rm_data )
    , .pc_plus8_o ( pc_plus8 )
    , .write_o    ( reg_write )
    , .redirect_o ( redirect )
    , .flags_o    ( flags_o )
  );

  reg_file reg_file_inst (
      .clk_i      ( clk_i )
    , .rn_addr_i  ( rn_addr )
    , .rm_addr_i  ( rm_addr )
    , .rn_data_o  ( rn_data )
    , .rm_data_o  ( rm_data )
    , .pc_plus8_i ( pc_plus8 )
    , .write_i    ( reg_write )
  );

  assign wb_o = reg_write;

endmodule

// File: design/execute.sv
`timescale 1ns/1ps

module execute (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 valid_i,
  input  cpu_pkg::fetch_item_t item_i,
  output logic                 pop_o,
  output logic [3:0]           rn_addr_o,
  output logic [3:0]           rm_addr_o,
  input  logic [31:0]          rn_data_i,
  input  logic [31:0]          rm_data_i,
  output logic [31:0]          pc_plus8_o,
  output cpu_pkg::reg_write_t  write_o,
  output cpu_pkg::redirect_t   redirect_o,
  output cpu_pkg::flags_t      flags_o
);

  import cpu_pkg::*;

  dp_fmt_t     dp;
  br_fmt_t     br;
  logic        is_dp;
  logic        is_br;
  logic        op_ok;
  logic        supported;
  logic        cond_ok;
  logic        fire;
  logic [4:0]  rot_amt;
  logic [63:0] imm_dbl;
  logic [31:0] op2;
  logic        shifter_c;
  logic        op_is_sub;
  logic [31:0] op2_eff;
  logic [32:0] sum;
  logic        overflow;
  logic        arith;
  logic [31:0] result;
  flags_t      next_flags;
  flags_t      flags_q;
  logic        wr_en_q;
  logic [3:0]  wr_addr_q;
  logic [31:0] wr_data_q;
  logic        redir_valid_q;
  logic [31:0] redir_target_q;

  function automatic logic cond_pass(input logic [3:0] cond, input flags_t f);
    case (cond)
      COND_EQ: return f.z;
      COND_NE: return !f.z;
      COND_CS: return f.c;
      COND_CC: return !f.c;
      COND_MI: return f.n;
      COND_PL: return !f.n;
      COND_VS: return f.v;
      COND_VC: return !f.v;
      COND_HI: return f.c && !f.z;
      COND_LS: return !f.c || f.z;
      COND_GE: return f.n == f.v;
      COND_LT: return f.n != f.v;
      COND_GT: return !f.z && (f.n == f.v);
      COND_LE: return f.z || (f.n != f.v);
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  ////////////////////
  // Decode
  ////////////////////

  assign dp    = item_i.inst.dp;
  assign br    = item_i.inst.br;
  assign is_dp = (dp.op_class == CLASS_DP);
  assign is_br = (br.op_class == CLASS_BR);
  assign op_ok = dp.opcode inside {OP_AND, OP_EOR, OP_SUB, OP_ADD,
                                   OP_CMP, OP_ORR, OP_MOV, OP_MVN};

  // Register operands carry no shift, and r15 is never a destination
  assign supported = (is_dp && op_ok && (dp.imm || (dp.operand2[11:4] == '0))
                      && ((dp.opcode == OP_CMP) ? dp.set_flags : (dp.rd != 4'd15)))
                   || (is_br && !br.link);

  // The head is stale while a redirect is out
  assign pop_o   = valid_i && !redir_valid_q;
  assign cond_ok = cond_pass(dp.cond, flags_q);
  assign fire    = pop_o && cond_ok;

  assign rn_addr_o  = dp.rn;
  assign rm_addr_o  = dp.operand2[3:0];
  assign pc_plus8_o = item_i.pc + 32'd8;

  ////////////////////
  // ALU
  ////////////////////

  assign rot_amt   = {dp.operand2[11:8], 1'b0};
  assign imm_dbl   = {24'd0, dp.operand2[7:0], 24'd0, dp.operand2[7:0]} >> rot_amt;
  assign op2       = dp.imm ? imm_dbl[31:0] : rm_data_i;
  assign shifter_c = (dp.imm && (rot_amt != '0)) ? imm_dbl[31] : flags_q.c;

  // Subtract is an add of the inverted operand with a carry in, so C means no borrow
  assign op_is_sub = (dp.opcode == OP_SUB) || (dp.opcode == OP_CMP);
  assign op2_eff   = op_is_sub ? ~op2 : op2;
  assign sum       = {1'b0, rn_data_i} + {1'b0, op2_eff} + {32'd0, op_is_sub};
  assign overflow  = (rn_data_i[31] == op2_eff[31]) && (sum[31] != rn_data_i[31]);

  always_comb begin
    arith = 1'b0;
    case (dp.opcode)
      OP_AND: result = rn_data_i & op2;
      OP_EOR: result = rn_data_i ^ op2;
      OP_SUB, OP_ADD, OP_CMP: begin
        result = sum[31:0];
        arith  = 1'b1;
      end
      OP_ORR: result = rn_data_i | op2;
      OP_MOV: result = op2;
      OP_MVN: result = ~op2;
      default: result = '0;
    endcase
  end

  assign next_flags.n = result[31];
  assign next_flags.z = (result == '0);
  assign next_flags.c = arith ? sum[32] : shifter_c;
  assign next_flags.v = arith ? overflow : flags_q.v;

  ////////////////////
  // Effects
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_q       <= '0;
      wr_en_q       <= 1'b0;
      redir_valid_q <= 1'b0;
    end else begin
      wr_en_q       <= fire && is_dp && op_ok && (dp.opcode != OP_CMP);
      redir_valid_q <= fire && is_br;
      if (fire && is_dp && op_ok && (dp.set_flags || (dp.opcode == OP_CMP))) begin
        flags_q <= next_flags;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    wr_addr_q      <= dp.rd;
    wr_data_q      <= result;
    redir_target_q <= pc_plus8_o + {{6{br.offset[23]}}, br.offset, 2'b00};
  end

  assign write_o.en        = wr_en_q;
  assign write_o.addr      = wr_addr_q;
  assign write_o.data      = wr_data_q;
  assign redirect_o.valid  = redir_valid_q;
  assign redirect_o.target = redir_target_q;
  assign flags_o           = flags_q;

  assert property (@(posedge clk_i) disable iff (reset_i) pop_o |-> supported)
    else $error("unsupported instruction %h at %h", item_i.inst, item_i.pc);

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                clk_i,
  input  logic [3:0]          rn_addr_i,
  input  logic [3:0]          rm_addr_i,
  output logic [31:0]         rn_data_o,
  output logic [31:0]         rm_data_o,
  input  logic [31:0]         pc_plus8_i,
  input  cpu_pkg::reg_write_t write_i
);

  logic [31:0] regs_q [0:14];
  logic        rn_hit;
  logic        rm_hit;

  // r15 is not stored here, it reads as the instruction address plus 8
  always_ff @(posedge clk_i) begin
    if (write_i.en && (write_i.addr != 4'd15)) begin
      regs_q[write_i.addr] <= write_i.data;
    end
  end

  // A write still on the port is returned to a read of the same register
  assign rn_hit = write_i.en && (write_i.addr == rn_addr_i);
  assign rm_hit = write_i.en && (write_i.addr == rm_addr_i);

  assign rn_data_o = (rn_addr_i == 4'd15) ? pc_plus8_i
                   : rn_hit               ? write_i.data
                   :                        regs_q[rn_addr_i];

  assign rm_data_o = (rm_addr_i == 4'd15) ? pc_plus8_i
                   : rm_hit               ? write_i.data
                   :                        regs_q[rm_addr_i];

endmodule

// File: design/inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            push_i,
  input  cpu_pkg::fetch_item_t            item_i,
  input  logic                            pop_i,
  input  logic                            flush_i,
  output logic                            valid_o,
  output cpu_pkg::fetch_item_t            item_o,
  output logic [cpu_pkg::QUEUE_CNT_W-1:0] free_slots_o
);

  import cpu_pkg::*;

  fetch_item_t            mem_q [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [QUEUE_CNT_W-1:0] count_q;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= item_i;
    end
  end

  assign valid_o      = (count_q != '0);
  assign item_o       = mem_q[rd_ptr_q];
  assign free_slots_o = QUEUE_CNT_W'(QUEUE_DEPTH) - count_q;

  ////////////////////
  // Checks
  ////////////////////

  // Fetch reserves a slot before it asks for a word
  assert property (@(posedge clk_i) disable iff (reset_i)
    push_i && !flush_i |-> count_q != QUEUE_CNT_W'(QUEUE_DEPTH))
    else $error("push into a full instruction queue");

  assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i && !flush_i |-> count_q != '0)
    else $error("pop from an empty instruction queue");

endmodule

// File: design/fetch.sv
`timescale 1ns/1ps

module fetch (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            imem_ack_i,
  input  logic [31:0]                     imem_data_i,
  output logic                            imem_req_o,
  output logic [31:0]                     imem_addr_o,
  input  logic [cpu_pkg::QUEUE_CNT_W-1:0] free_slots_i,
  input  cpu_pkg::redirect_t              redirect_i,
  output logic                            push_o,
  output cpu_pkg::fetch_item_t            item_o
);

  import cpu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_ACK_LOW
  } state_t;

  state_t      state_q;
  logic [31:0] pc_q;
  logic [31:0] addr_q;
  logic        discard_q;
  logic        push_q;
  fetch_item_t item_q;
  logic        start;
  logic        capture;
  logic        capture_ok;

  // A captured word that has not reached the queue still holds a slot
  assign start = !redirect_i.valid
              && (free_slots_i > {{(QUEUE_CNT_W-1){1'b0}}, push_q})
              && ((state_q == S_IDLE) || ((state_q == S_ACK_LOW) && !imem_ack_i));

  assign capture    = (state_q == S_REQ) && imem_ack_i;
  assign capture_ok = capture && !discard_q && !redirect_i.valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= S_IDLE;
      pc_q      <= '0;
      discard_q <= 1'b0;
      push_q    <= 1'b0;
    end else begin
      push_q <= capture_ok;
      case (state_q)
        S_REQ: begin
          if (imem_ack_i) begin
            state_q   <= S_ACK_LOW;
            discard_q <= 1'b0;
          end else if (redirect_i.valid) begin
            discard_q <= 1'b1;
          end
        end
        S_ACK_LOW: begin
          if (!imem_ack_i) begin
            state_q <= start ? S_REQ : S_IDLE;
          end
        end
        default: begin
          if (start) begin
            state_q <= S_REQ;
          end
        end
      endcase
      if (redirect_i.valid) begin
        pc_q <= redirect_i.target;
      end else if (capture_ok) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q <= pc_q;
    end
    if (capture) begin
      item_q.pc   <= addr_q;
      item_q.inst <= imem_data_i;
    end
  end

  assign imem_req_o  = (state_q == S_REQ);
  assign imem_addr_o = addr_q;
  assign push_o      = push_q;
  assign item_o      = item_q;

  // The source samples the address for as long as req is up
  assert property (@(posedge clk_i) disable iff (reset_i)
    imem_req_o |=> !imem_req_o || $stable(imem_addr_o))
    else $error("imem_addr_o changed during a request");

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

  ////////////////////
  // Queue sizing
  ////////////////////

  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  ////////////////////
  // Encodings
  ////////////////////

  localparam logic [1:0] CLASS_DP = 2'b00;
  localparam logic [2:0] CLASS_BR = 3'b101;

  localparam logic [3:0] OP_AND = 4'h0;
  localparam logic [3:0] OP_EOR = 4'h1;
  localparam logic [3:0] OP_SUB = 4'h2;
  localparam logic [3:0] OP_ADD = 4'h4;
  localparam logic [3:0] OP_CMP = 4'ha;
  localparam logic [3:0] OP_ORR = 4'hc;
  localparam logic [3:0] OP_MOV = 4'hd;
  localparam logic [3:0] OP_MVN = 4'hf;

  localparam logic [3:0] COND_EQ = 4'h0;
  localparam logic [3:0] COND_NE = 4'h1;
  localparam logic [3:0] COND_CS = 4'h2;
  localparam logic [3:0] COND_CC = 4'h3;
  localparam logic [3:0] COND_MI = 4'h4;
  localparam logic [3:0] COND_PL = 4'h5;
  localparam logic [3:0] COND_VS = 4'h6;
  localparam logic [3:0] COND_VC = 4'h7;
  localparam logic [3:0] COND_HI = 4'h8;
  localparam logic [3:0] COND_LS = 4'h9;
  localparam logic [3:0] COND_GE = 4'ha;
  localparam logic [3:0] COND_LT = 4'hb;
  localparam logic [3:0] COND_GT = 4'hc;
  localparam logic [3:0] COND_LE = 4'hd;
  localparam logic [3:0] COND_AL = 4'he;

  ////////////////////
  // Instruction views
  ////////////////////

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op_class;
    logic        imm;
    logic [3:0]  opcode;
    logic        set_flags;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dp_fmt_t;

  typedef struct packed {
    logic [3:0]  cond;
    logic [2:0]  op_class;
    logic        link;
    logic [23:0] offset;
  } br_fmt_t;

  // Execute picks the view from the class bits
  typedef union packed {
    dp_fmt_t dp;
    br_fmt_t br;
  } inst_u;

  typedef struct packed {
    logic [31:0] pc;
    inst_u       inst;
  } fetch_item_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  typedef struct packed {
    logic        en;
    logic [3:0]  addr;
    logic [31:0] data;
  } reg_write_t;

endpackage
